//--- common/throttle_cfg.svh
// Build configuration for the clock throttle subsystem
// Skip counter width, trigger mode, measurement widths
// and Wishbone bus widths

`ifndef THROTTLE_CFG_SVH
`define THROTTLE_CFG_SVH

// Skip counter and skip value width
// Integration rule: must be at least 2
`define THR_CNTR_WIDTH 3

// Trigger mode
// Integration rule: 0 or 1 only, 1 means trigger is already on clk_in
`define THR_SYNC_TRIGGER 0

// Measurement window length and active count width
`define THR_WINDOW_WIDTH 16

// Wishbone classic bus widths
`define WB_ADR_WIDTH 8
`define WB_DAT_WIDTH 32

`endif

//--- common/wb_pkg.sv
// Wishbone classic bus types
// Request and response structs
// Register map offsets of the throttle slave

`default_nettype none

`include "throttle_cfg.svh"

package wb_pkg;

  // One byte lane per 8 data bits
  localparam int WB_SEL_WIDTH = `WB_DAT_WIDTH / 8;

  // Master to slave
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [WB_SEL_WIDTH-1:0]   sel;
    logic [`WB_ADR_WIDTH-1:0]  adr;
    logic [`WB_DAT_WIDTH-1:0]  dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                      ack;
    logic [`WB_DAT_WIDTH-1:0]  dat;
  } wb_rsp_t;

  // Register byte offsets
  typedef enum logic [`WB_ADR_WIDTH-1:0] {
    REG_CTRL   = `WB_ADR_WIDTH'('h00),
    REG_SKIP   = `WB_ADR_WIDTH'('h04),
    REG_WINDOW = `WB_ADR_WIDTH'('h08),
    REG_STATUS = `WB_ADR_WIDTH'('h0C),
    REG_ACTIVE = `WB_ADR_WIDTH'('h10)
  } reg_addr_e;

endpackage

`default_nettype wire

//--- common/throttle_pkg.sv
// Throttle control and activity measurement types
// Control struct from register slave to throttle
// Measurement command and result structs
// Measurement FSM state enum

`default_nettype none

`include "throttle_cfg.svh"

package throttle_pkg;

  // ------------------------------
  // Throttle control
  // ------------------------------
  typedef struct packed {
    logic                          throttle_en;
    logic [`THR_CNTR_WIDTH-1:0]    skip_value;
  } throttle_ctrl_t;

  // ------------------------------
  // Activity measurement
  // ------------------------------

  // Monitor FSM states
  typedef enum logic [1:0] {
    MEAS_IDLE = 2'd0,
    MEAS_RUN  = 2'd1,
    MEAS_DONE = 2'd2
  } meas_state_e;

  // Start is a single-cycle pulse
  typedef struct packed {
    logic                          start;
    logic [`THR_WINDOW_WIDTH-1:0]  window_len;
  } meas_cmd_t;

  typedef struct packed {
    logic                          done;
    logic [`THR_WINDOW_WIDTH-1:0]  active_count;
  } meas_result_t;

endpackage

`default_nettype wire

//--- hw/clock_throttle/clock_throttle.sv
// Clock throttle decision logic
// Optional two-flop trigger synchronizer
// Wrapping skip counter
// Combinational clock enable

`default_nettype none

`include "throttle_cfg.svh"

module clock_throttle import throttle_pkg::*; #(
  // 1 when trigger is already synchronous to clk_in
  parameter bit SYNC_TRIGGER = 1'b0
) (
  input  wire logic           clk_in,
  input  wire logic           rst_n,
  input  wire logic           trigger,
  input  wire throttle_ctrl_t ctrl,
  output logic                clk_en
);

  logic                        trig_s;
  logic                        cntr_run;
  logic [`THR_CNTR_WIDTH-1:0]  cntr_q;

  // ------------------------------
  // Trigger input
  // ------------------------------
  if (SYNC_TRIGGER) begin : gen_sync_trigger
    // Used as is in the same cycle
    assign trig_s = trigger;
  end else begin : gen_async_trigger
    logic [1:0] sync_q;

    // Two-flop synchronizer
    // trigger shows up after two clk_in edges
    always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
        sync_q <= 2'b00;
      end else begin
        sync_q <= {sync_q[0], trigger};
      end
    end

    assign trig_s = sync_q[1];
  end

  // ------------------------------
  // Skip counter
  // ------------------------------

  // Counts only while throttling and triggered
  assign cntr_run = ctrl.throttle_en && trig_s;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      cntr_q <= '0;
    end else if (!cntr_run) begin
      cntr_q <= '0;
    end else begin
      // Wraps from all ones back to zero
      cntr_q <= cntr_q + `THR_CNTR_WIDTH'(1);
    end
  end

  // ------------------------------
  // Clock enable
  // ------------------------------

  // Pulses with count below skip_value get swallowed
  assign clk_en = !ctrl.throttle_en || !trig_s || (cntr_q >= ctrl.skip_value);

endmodule

`default_nettype wire

//--- hw/clock_throttle/clock_gate.sv
// Integrated clock gate
// Low-transparent enable latch with async clear
// Latched enable ANDed with the input clock

`default_nettype none

module clock_gate (
  input  wire logic clk_in,
  input  wire logic rst_n,
  input  wire logic en,
  output logic      clk_out
);

  logic en_l;

  // Latch follows en while clk_in is low
  // Holds during the high phase so no glitch on clk_out
  always_latch begin
    if (!rst_n) begin
      en_l <= 1'b0;
    end else if (!clk_in) begin
      en_l <= en;
    end
  end

  // Output stays low under reset since en_l is cleared
  assign clk_out = clk_in & en_l;

endmodule

`default_nettype wire

//--- hw/activity_monitor.sv
// Clock activity monitor
// Counts clk_in cycles with clk_en high over a programmed window
// FSM goes IDLE, RUN, DONE and restarts on every start pulse

`default_nettype none

`include "throttle_cfg.svh"

module activity_monitor import throttle_pkg::*; (
  input  wire logic         clk_in,
  input  wire logic         rst_n,
  input  wire logic         clk_en,
  input  wire meas_cmd_t    cmd,
  output meas_result_t      result
);

  meas_state_e                   state_q;
  logic [`THR_WINDOW_WIDTH-1:0]  remain_q;
  logic [`THR_WINDOW_WIDTH-1:0]  count_q;

  // ------------------------------
  // Measurement FSM
  // ------------------------------
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= MEAS_IDLE;
      remain_q <= '0;
      count_q  <= '0;
    end else if (cmd.start) begin
      // Clear result and load window, from any state
      count_q  <= '0;
      remain_q <= cmd.window_len;
      // Empty window finishes at once
      if (cmd.window_len == '0) begin
        state_q <= MEAS_DONE;
      end else begin
        state_q <= MEAS_RUN;
      end
    end else begin
      case (state_q)
        MEAS_RUN: begin
          // One sample of clk_en per edge
          count_q  <= count_q + `THR_WINDOW_WIDTH'(clk_en);
          remain_q <= remain_q - `THR_WINDOW_WIDTH'(1);
          // Last sample of the window
          if (remain_q == `THR_WINDOW_WIDTH'(1)) begin
            state_q <= MEAS_DONE;
          end
        end
        // Result held until next start
        MEAS_DONE: state_q <= MEAS_DONE;
        default:   state_q <= MEAS_IDLE;
      endcase
    end
  end

  assign result.done         = (state_q == MEAS_DONE);
  assign result.active_count = count_q;

endmodule

`default_nettype wire

//--- hw/throttle_regs.sv
// Wishbone classic register slave for the clock throttle
// Holds CTRL, SKIP and WINDOW registers
// Single-cycle ack, byte-lane writes
// WINDOW write issues the measurement start pulse
// STATUS and ACTIVE read back from the monitor result

`default_nettype none

`include "throttle_cfg.svh"

module throttle_regs import throttle_pkg::*, wb_pkg::*; (
  input  wire logic         clk_in,
  input  wire logic         rst_n,
  input  wire wb_req_t      wb_req,
  output wb_rsp_t           wb_rsp,
  output throttle_ctrl_t    ctrl,
  output meas_cmd_t         meas_cmd,
  input  wire meas_result_t meas_result
);

  logic                           ack_q;
  logic                           start_q;
  logic [`WB_DAT_WIDTH-1:0]       dat_q;
  throttle_ctrl_t                 ctrl_q;
  logic [`THR_WINDOW_WIDTH-1:0]   window_q;

  logic                           access;
  logic                           wr_en;
  reg_addr_e                      addr;

  // Zero-extended register views
  logic [`WB_DAT_WIDTH-1:0]       ctrl_rdata;
  logic [`WB_DAT_WIDTH-1:0]       skip_rdata;
  logic [`WB_DAT_WIDTH-1:0]       window_rdata;
  logic [`WB_DAT_WIDTH-1:0]       status_rdata;
  logic [`WB_DAT_WIDTH-1:0]       active_rdata;
  logic [`WB_DAT_WIDTH-1:0]       rd_mux;

  // Register views after byte-lane merge
  logic [`WB_DAT_WIDTH-1:0]       ctrl_wdata;
  logic [`WB_DAT_WIDTH-1:0]       skip_wdata;
  logic [`WB_DAT_WIDTH-1:0]       window_wdata;

  // Replace only the byte lanes selected by sel
  function automatic logic [`WB_DAT_WIDTH-1:0] byte_merge(
    input logic [`WB_DAT_WIDTH-1:0] old_val,
    input logic [`WB_DAT_WIDTH-1:0] new_val,
    input logic [WB_SEL_WIDTH-1:0]  sel
  );
    logic [`WB_DAT_WIDTH-1:0] res;
    res = old_val;
    for (int i = 0; i < WB_SEL_WIDTH; i++) begin
      if (sel[i]) begin
        res[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // Bus handshake
  // ------------------------------

  // First cycle of a transfer, ack not yet given
  assign access = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_en  = access && wb_req.we;
  assign addr   = reg_addr_e'(wb_req.adr);

  // ------------------------------
  // Read path
  // ------------------------------
  assign ctrl_rdata   = {{(`WB_DAT_WIDTH-1){1'b0}}, ctrl_q.throttle_en};
  assign skip_rdata   = {{(`WB_DAT_WIDTH-`THR_CNTR_WIDTH){1'b0}}, ctrl_q.skip_value};
  assign window_rdata = {{(`WB_DAT_WIDTH-`THR_WINDOW_WIDTH){1'b0}}, window_q};
  assign status_rdata = {{(`WB_DAT_WIDTH-1){1'b0}}, meas_result.done};
  assign active_rdata = {{(`WB_DAT_WIDTH-`THR_WINDOW_WIDTH){1'b0}},
                         meas_result.active_count};

  always_comb begin
    case (addr)
      REG_CTRL:   rd_mux = ctrl_rdata;
      REG_SKIP:   rd_mux = skip_rdata;
      REG_WINDOW: rd_mux = window_rdata;
      REG_STATUS: rd_mux = status_rdata;
      REG_ACTIVE: rd_mux = active_rdata;
      // Unmapped offsets read as zero
      default:    rd_mux = '0;
    endcase
  end

  // ------------------------------
  // Write path
  // ------------------------------
  assign ctrl_wdata   = byte_merge(ctrl_rdata, wb_req.dat, wb_req.sel);
  assign skip_wdata   = byte_merge(skip_rdata, wb_req.dat, wb_req.sel);
  assign window_wdata = byte_merge(window_rdata, wb_req.dat, wb_req.sel);

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      ack_q    <= 1'b0;
      start_q  <= 1'b0;
      ctrl_q   <= '0;
      window_q <= '0;
    end else begin
      // Ack drops on the following edge even if stb stays high
      ack_q   <= access;
      start_q <= 1'b0;
      if (wr_en) begin
        case (addr)
          REG_CTRL: ctrl_q.throttle_en <= ctrl_wdata[0];
          REG_SKIP: ctrl_q.skip_value  <= skip_wdata[`THR_CNTR_WIDTH-1:0];
          REG_WINDOW: begin
            window_q <= window_wdata[`THR_WINDOW_WIDTH-1:0];
            start_q  <= 1'b1;
          end
          // STATUS, ACTIVE and unmapped writes are dropped
          default: ;
        endcase
      end
    end
  end

  // Read data lands together with ack
  always_ff @(posedge clk_in) begin
    if (access) begin
      dat_q <= rd_mux;
    end
  end

  assign wb_rsp.ack          = ack_q;
  assign wb_rsp.dat          = dat_q;
  assign ctrl                = ctrl_q;
  assign meas_cmd.start      = start_q;
  assign meas_cmd.window_len = window_q;

endmodule

`default_nettype wire

//--- hw/throttle_top.sv
// Clock throttle subsystem top level
// Wishbone register slave, throttle decision logic,
// clock gate and activity monitor

`default_nettype none

`include "throttle_cfg.svh"

module throttle_top import throttle_pkg::*, wb_pkg::*; (
  input  wire logic    clk_in,
  input  wire logic    rst_n,
  input  wire wb_req_t wb_req,
  output wb_rsp_t      wb_rsp,
  input  wire logic    trigger,
  output logic         clk_out
);

  throttle_ctrl_t ctrl;
  meas_cmd_t      meas_cmd;
  meas_result_t   meas_result;
  logic           clk_en;

  // Software register block
  throttle_regs u_regs (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .ctrl        (ctrl),
    .meas_cmd    (meas_cmd),
    .meas_result (meas_result)
  );

  // Enable decision from trigger and skip counter
  clock_throttle #(
    .SYNC_TRIGGER (`THR_SYNC_TRIGGER != 0)
  ) u_throttle (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .trigger (trigger),
    .ctrl    (ctrl),
    .clk_en  (clk_en)
  );

  // Pulse swallowing gate
  clock_gate u_gate (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .en      (clk_en),
    .clk_out (clk_out)
  );

  // Counts passed pulses over a window
  activity_monitor u_monitor (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .clk_en (clk_en),
    .cmd    (meas_cmd),
    .result (meas_result)
  );

endmodule

`default_nettype wire

//--- dv/throttle_tb.sv
// Testbench for the clock throttle subsystem
// Wishbone classic read and write tasks with ack timeout
// Reset value and register readback checks
// Table of throttle settings with expected active counts
// Direct count of clk_out pulses over one window

`default_nettype none

`include "throttle_cfg.svh"

module throttle_tb import wb_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Skip counter period
  localparam int P             = 1 << `THR_CNTR_WIDTH;
  localparam int NUM_ROWS      = 6;
  localparam int ACK_TIMEOUT   = 20;
  localparam int DONE_POLLS    = 200;
  localparam int SETTLE_CYCLES = 8;

  // One row of stimulus
  typedef struct packed {
    logic                          throttle_en;
    logic                          trig_level;
    logic [`THR_CNTR_WIDTH-1:0]    skip_value;
    logic [`THR_WINDOW_WIDTH-1:0]  window_len;
  } stim_row_t;

  logic      clk_in;
  logic      rst_n;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;
  logic      trigger;
  logic      clk_out;

  stim_row_t rows [NUM_ROWS];
  string     names [NUM_ROWS];
  int        errors;
  int        timeouts;
  int        checks;
  int        seed;

  throttle_top dut0 (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .trigger (trigger),
    .clk_out (clk_out)
  );

  // 100 ns clock
  initial begin
    clk_in = 1'b0;
    forever begin
      #50 clk_in = ~clk_in;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [`WB_DAT_WIDTH-1:0] expected,
                             input logic [`WB_DAT_WIDTH-1:0] actual);
    checks++;
    assert (actual == expected) else begin
      $display("error: %s expected %0d actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  // One classic cycle, request held until ack
  task automatic bus_cycle(input logic we, input logic [`WB_ADR_WIDTH-1:0] adr,
                           input logic [`WB_DAT_WIDTH-1:0] wdata,
                           output logic [`WB_DAT_WIDTH-1:0] rdata);
    wb_req_t req;
    int      waited;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.sel = '1;
    req.adr = adr;
    req.dat = wdata;
    rdata   = '0;
    waited  = 0;
    @(posedge clk_in);
    wb_req <= req;
    // Ack sampled in the low phase
    do begin
      @(negedge clk_in);
      waited++;
    end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
    if (wb_rsp.ack) begin
      rdata = wb_rsp.dat;
    end else begin
      $display("slave gave no ack for address 0x%02h", adr);
      timeouts++;
    end
    @(posedge clk_in);
    wb_req <= '0;
  endtask

  task automatic wb_write(input logic [`WB_ADR_WIDTH-1:0] adr,
                          input logic [`WB_DAT_WIDTH-1:0] wdata);
    logic [`WB_DAT_WIDTH-1:0] unused;
    bus_cycle(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input logic [`WB_ADR_WIDTH-1:0] adr,
                         output logic [`WB_DAT_WIDTH-1:0] rdata);
    bus_cycle(1'b0, adr, '0, rdata);
  endtask

  // Poll STATUS.done
  task automatic wait_done(input string name, output logic done_seen);
    logic [`WB_DAT_WIDTH-1:0] status;
    int                       polls;
    done_seen = 1'b0;
    polls     = 0;
    while (!done_seen && polls < DONE_POLLS) begin
      wb_read(REG_STATUS, status);
      done_seen = status[0];
      polls++;
    end
    if (!done_seen) begin
      $display("measurement %s never reported done", name);
      timeouts++;
    end
  endtask

  // Gated clock is stable in the middle of the high phase
  task automatic count_pulses(input int cycles, output int pulses);
    pulses = 0;
    repeat (cycles) begin
      @(posedge clk_in);
      #25;
      if (clk_out) begin
        pulses++;
      end
    end
  endtask

  // P - skip_value of every P cycles pass, whatever the counter phase
  function automatic int expected_active(input stim_row_t row);
    if (!row.throttle_en || !row.trig_level) begin
      return int'(row.window_len);
    end
    return (int'(row.window_len) / P) * (P - int'(row.skip_value));
  endfunction

  task automatic load_table();
    names[0] = "throttle_off";
    rows[0]  = '{1'b0, 1'b1, `THR_CNTR_WIDTH'(P - 1), `THR_WINDOW_WIDTH'(40)};
    names[1] = "trigger_low";
    rows[1]  = '{1'b1, 1'b0, `THR_CNTR_WIDTH'(P / 2), `THR_WINDOW_WIDTH'(24)};
    names[2] = "skip_zero";
    rows[2]  = '{1'b1, 1'b1, `THR_CNTR_WIDTH'(0), `THR_WINDOW_WIDTH'(4 * P)};
    names[3] = "skip_one";
    rows[3]  = '{1'b1, 1'b1, `THR_CNTR_WIDTH'(1), `THR_WINDOW_WIDTH'(4 * P)};
    names[4] = "skip_half";
    rows[4]  = '{1'b1, 1'b1, `THR_CNTR_WIDTH'(P / 2), `THR_WINDOW_WIDTH'(8 * P)};
    names[5] = "skip_max";
    rows[5]  = '{1'b1, 1'b1, `THR_CNTR_WIDTH'(P - 1), `THR_WINDOW_WIDTH'(6 * P)};
  endtask

  task automatic run_row(input string name, input stim_row_t row);
    logic [`WB_DAT_WIDTH-1:0] active;
    logic                     done_seen;
    wb_write(REG_CTRL, `WB_DAT_WIDTH'(row.throttle_en));
    wb_write(REG_SKIP, `WB_DAT_WIDTH'(row.skip_value));
    @(posedge clk_in);
    trigger <= row.trig_level;
    // Let the synchronizer and counter settle
    repeat (SETTLE_CYCLES) @(posedge clk_in);
    wb_write(REG_WINDOW, `WB_DAT_WIDTH'(row.window_len));
    wait_done(name, done_seen);
    if (done_seen) begin
      wb_read(REG_ACTIVE, active);
      check_value(name, `WB_DAT_WIDTH'(expected_active(row)), active);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [`WB_DAT_WIDTH-1:0] rdata;
    logic [`WB_DAT_WIDTH-1:0] skip_rand;
    logic                     done_seen;
    int                       pulses;
    wb_req   = '0;
    trigger  = 1'b0;
    rst_n    = 1'b0;
    errors   = 0;
    timeouts = 0;
    checks   = 0;
    seed     = 98;
    load_table();
    repeat (5) @(posedge clk_in);
    rst_n <= 1'b1;
    @(posedge clk_in);

    // Reset values and unmapped offsets
    wb_read(REG_STATUS, rdata);
    check_value("reset_status", '0, rdata);
    wb_read(REG_CTRL, rdata);
    check_value("reset_ctrl", '0, rdata);
    wb_read(REG_SKIP, rdata);
    check_value("reset_skip", '0, rdata);
    wb_read(`WB_ADR_WIDTH'('h14), rdata);
    check_value("unmapped_14", '0, rdata);
    wb_read(`WB_ADR_WIDTH'('hFC), rdata);
    check_value("unmapped_fc", '0, rdata);

    // Readback of written control values
    wb_write(REG_CTRL, `WB_DAT_WIDTH'(1));
    wb_read(REG_CTRL, rdata);
    check_value("ctrl_readback", `WB_DAT_WIDTH'(1), rdata);
    skip_rand = `WB_DAT_WIDTH'($random(seed)) & `WB_DAT_WIDTH'(P - 1);
    wb_write(REG_SKIP, skip_rand);
    wb_read(REG_SKIP, rdata);
    check_value("skip_readback", skip_rand, rdata);
    wb_write(REG_CTRL, '0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(names[i], rows[i]);
    end

    // Count clk_out pulses against ACTIVE, skip of 3 fits any P
    wb_write(REG_CTRL, `WB_DAT_WIDTH'(1));
    wb_write(REG_SKIP, `WB_DAT_WIDTH'(3));
    @(posedge clk_in);
    trigger <= 1'b1;
    repeat (SETTLE_CYCLES) @(posedge clk_in);
    wb_write(REG_WINDOW, `WB_DAT_WIDTH'(8 * P));
    count_pulses(8 * P, pulses);
    check_value("pulse_formula", `WB_DAT_WIDTH'(8 * (P - 3)), `WB_DAT_WIDTH'(pulses));
    wait_done("pulse_count", done_seen);
    if (done_seen) begin
      wb_read(REG_ACTIVE, rdata);
      check_value("pulse_count", `WB_DAT_WIDTH'(pulses), rdata);
    end

    // Unmapped offsets again while every mapped register is non-zero
    wb_read(`WB_ADR_WIDTH'('h14), rdata);
    check_value("unmapped_14_live", '0, rdata);
    wb_read(`WB_ADR_WIDTH'('hFC), rdata);
    check_value("unmapped_fc_live", '0, rdata);

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
common/wb_pkg.sv
common/throttle_pkg.sv
hw/clock_throttle/clock_throttle.sv
hw/clock_throttle/clock_gate.sv
hw/activity_monitor.sv
hw/throttle_regs.sv
hw/throttle_top.sv
dv/throttle_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the clock throttle testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module throttle_tb -f compile.f \
  || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vthrottle_tb) || { echo "$out"; echo "simulation aborted"; exit 1; }
echo "$out"
echo "$out" | grep -qx "Result: PASSED" && exit 0 \
  || { echo "simulation did not report a pass"; exit 1; }
